//--- src/mem_req_pkg.sv
package mem_req_pkg;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } mem_size_e;

    // single access carried from tx_clk to rx_clk.
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
        mem_size_e   size;
        logic [6:0]  prot;
        logic        secen;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        slverr;
    } mem_rsp_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        mem_req_t req;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- src/axi_bridge_pkg.sv
package axi_bridge_pkg;

    localparam int          AXI_ID_W         = 9;
    localparam int          MEM_WORDS        = 256;
    localparam int          MEM_AW           = $clog2(MEM_WORDS);
    localparam logic [31:0] SECURE_BASE      = 32'h300;
    localparam int          RX_IGNORE_CYCLES = 15;
    localparam int          RX_IGN_W         = $clog2(RX_IGNORE_CYCLES + 1);

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [AXI_ID_W-1:0] awid;
        logic [31:0]         awaddr;
        logic [7:0]          awlen;
        logic [1:0]          awsize;
        axi_burst_e          awburst;
        logic [1:0]          awlock;
        logic [3:0]          awcache;
        logic [2:0]          awprot;
        logic                awvalid;
        logic [AXI_ID_W-1:0] wid;
        logic [31:0]         wdata;
        logic [3:0]          wstrb;
        logic                wlast;
        logic                wvalid;
        logic                bready;
        logic [AXI_ID_W-1:0] arid;
        logic [31:0]         araddr;
        logic [7:0]          arlen;
        logic [1:0]          arsize;
        axi_burst_e          arburst;
        logic [1:0]          arlock;
        logic [3:0]          arcache;
        logic [2:0]          arprot;
        logic                arvalid;
        logic                rready;
    } axi_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axi_resp_e   bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axi_resp_e   rresp;
        logic        rlast;
    } axi_rsp_t;

endpackage

//--- src/mem_req_tx.sv
`timescale 1ns/1ps

module mem_req_tx
    import mem_req_pkg::*;
(
    input  logic     tx_clk,
    input  logic     tx_rstn,
    input  wb_req_t  wb_req,
    input  logic     rx_tog,
    input  mem_rsp_t rx_rsp,
    output wb_rsp_t  wb_rsp,
    output logic     tx_tog,
    output mem_req_t tx_req
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } tx_state_e;

    tx_state_e   state;
    logic        rx_tog_s1;
    logic        rx_tog_s2;
    logic        rx_seen;
    logic        start;
    logic        rx_done;
    logic        ack_q;
    logic        err_q;
    logic [31:0] dat_q;

    assign start   = (state == IDLE) && wb_req.cyc && wb_req.stb;
    assign rx_done = (state == BUSY) && (rx_tog_s2 != rx_seen);

    always_ff @(posedge tx_clk or negedge tx_rstn) begin
        if (~tx_rstn) begin
            rx_tog_s1 <= 1'b0;
            rx_tog_s2 <= 1'b0;
        end else begin
            rx_tog_s1 <= rx_tog;
            rx_tog_s2 <= rx_tog_s1;
        end
    end

    always_ff @(posedge tx_clk or negedge tx_rstn) begin
        if (~tx_rstn) begin
            state   <= IDLE;
            tx_tog  <= 1'b0;
            rx_seen <= 1'b0;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        tx_tog <= ~tx_tog;           // hand request to rx side.
                        state  <= BUSY;
                    end
                end
                BUSY: begin
                    if (rx_done) begin
                        rx_seen <= rx_tog_s2;
                        ack_q   <= ~rx_rsp.slverr;
                        err_q   <= rx_rsp.slverr;
                        state   <= DONE;
                    end
                end
                DONE: begin
                    if (~wb_req.stb) begin
                        state <= IDLE;               // master released stb.
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // held stable until rx_tog returns.
    always_ff @(posedge tx_clk) begin
        if (start) begin
            tx_req <= wb_req.req;
        end
        if (rx_done) begin
            dat_q <= rx_rsp.rdata;
        end
    end

    assign wb_rsp = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

//--- src/axi_rx.sv
`timescale 1ns/1ps

module axi_rx
    import mem_req_pkg::*;
    import axi_bridge_pkg::*;
(
    input  logic     rx_clk,
    input  logic     rx_rstn,
    input  logic     tx_tog,
    input  mem_req_t tx_req,
    input  axi_rsp_t axi_rsp,
    output logic     rx_tog,
    output mem_rsp_t rx_rsp,
    output axi_req_t axi_req
);

    logic [RX_IGN_W-1:0] ign_cnt;
    logic                tx_tog_s1;
    logic                tx_tog_s2;
    logic                tx_tog_s3;
    logic                tx_rec;
    logic                rec_dly;
    mem_req_t            req_q;

    logic        burst;
    logic [1:0]  off;
    logic [3:0]  bmask;
    logic [31:0] byte_mask;
    logic [63:0] wdata_sh;
    logic [7:0]  wstrb_sh;
    logic [63:0] rd_pair;
    logic [63:0] rd_shift;

    logic [31:0] a_addr;
    logic [7:0]  a_len;
    logic [2:0]  a_prot;
    logic        aw_valid;
    logic        ar_valid;
    logic        w_valid;
    logic        w_last;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic [31:0] rd_lo;
    logic        rd_lo_err;

    logic        w_hs;
    logic        r_hs;
    logic        r_done;
    logic        b_hs;

    assign tx_rec = (tx_tog_s2 ^ tx_tog_s3) & ~(|ign_cnt);

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (~rx_rstn) begin
            ign_cnt   <= RX_IGN_W'(RX_IGNORE_CYCLES);
            tx_tog_s1 <= 1'b0;
            tx_tog_s2 <= 1'b0;
            tx_tog_s3 <= 1'b0;
            rec_dly   <= 1'b0;
        end else begin
            if (|ign_cnt) begin
                ign_cnt <= ign_cnt - 1'b1;
            end
            tx_tog_s1 <= tx_tog;
            tx_tog_s2 <= tx_tog_s1;
            tx_tog_s3 <= tx_tog_s2;                  // edge flop.
            rec_dly   <= tx_rec;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (tx_rec) begin
            req_q <= tx_req;
        end
    end

    assign off   = req_q.addr[1:0];
    assign burst = ({1'b0, off} + (3'd1 << req_q.size)) > 3'd4;

    always_comb begin
        case (req_q.size)
            SIZE_BYTE: bmask = 4'b0001;
            SIZE_HALF: bmask = 4'b0011;
            default:   bmask = 4'b1111;
        endcase
    end

    assign byte_mask = {{8{bmask[3]}}, {8{bmask[2]}}, {8{bmask[1]}}, {8{bmask[0]}}};
    assign wdata_sh  = {32'b0, req_q.wdata} << {off, 3'b000};
    assign wstrb_sh  = {4'b0, bmask} << off;

    assign w_hs   = w_valid & axi_rsp.wready;
    assign r_hs   = axi_rsp.rvalid;                  // rready is tied high.
    assign r_done = r_hs & axi_rsp.rlast;
    assign b_hs   = axi_rsp.bvalid;

    always_ff @(posedge rx_clk) begin
        if (rec_dly) begin
            a_addr <= {req_q.addr[31:2], 2'b00};
            a_len  <= {7'b0, burst};
            a_prot <= req_q.prot[2:0] & {1'b1, req_q.secen, 1'b1};
        end
    end

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (~rx_rstn) begin
            aw_valid <= 1'b0;
            ar_valid <= 1'b0;
            w_valid  <= 1'b0;
            w_last   <= 1'b0;
            rx_tog   <= 1'b0;
        end else begin
            if (rec_dly && req_q.write) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
                w_last   <= ~burst;
            end else begin
                if (axi_rsp.awready) begin
                    aw_valid <= 1'b0;
                end
                if (w_hs && w_last) begin
                    w_valid <= 1'b0;
                end else if (w_hs) begin
                    w_last <= 1'b1;
                end
            end
            if (rec_dly && ~req_q.write) begin
                ar_valid <= 1'b1;
            end else if (axi_rsp.arready) begin
                ar_valid <= 1'b0;
            end
            rx_tog <= rx_tog ^ (r_done | b_hs);
        end
    end

    // second beat carries the bytes spilled past the word.
    always_ff @(posedge rx_clk) begin
        if (rec_dly && req_q.write) begin
            w_data <= wdata_sh[31:0];
            w_strb <= wstrb_sh[3:0];
        end else if (w_hs && ~w_last) begin
            w_data <= wdata_sh[63:32];
            w_strb <= wstrb_sh[7:4];
        end
    end

    assign rd_pair  = burst ? {axi_rsp.rdata, rd_lo} : {32'b0, axi_rsp.rdata};
    assign rd_shift = rd_pair >> {off, 3'b000};

    always_ff @(posedge rx_clk) begin
        if (r_hs && ~axi_rsp.rlast) begin
            rd_lo     <= axi_rsp.rdata;
            rd_lo_err <= axi_rsp.rresp[1];
        end
        if (r_done) begin
            rx_rsp.rdata  <= rd_shift[31:0] & byte_mask;
            rx_rsp.slverr <= axi_rsp.rresp[1] | (burst & rd_lo_err);
        end else if (b_hs) begin
            rx_rsp.rdata  <= 32'b0;
            rx_rsp.slverr <= axi_rsp.bresp[1];
        end
    end

    always_comb begin
        axi_req         = '0;                        // ids, lock and cache stay 0.
        axi_req.awaddr  = a_addr;
        axi_req.awlen   = a_len;
        axi_req.awsize  = 2'd2;
        axi_req.awburst = BURST_INCR;
        axi_req.awprot  = a_prot;
        axi_req.awvalid = aw_valid;
        axi_req.wdata   = w_data;
        axi_req.wstrb   = w_strb;
        axi_req.wlast   = w_last;
        axi_req.wvalid  = w_valid;
        axi_req.bready  = 1'b1;
        axi_req.araddr  = a_addr;
        axi_req.arlen   = a_len;
        axi_req.arsize  = 2'd2;
        axi_req.arburst = BURST_INCR;
        axi_req.arprot  = a_prot;
        axi_req.arvalid = ar_valid;
        axi_req.rready  = 1'b1;
    end

endmodule

//--- src/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave
    import axi_bridge_pkg::*;
(
    input  logic     rx_clk,
    input  logic     rx_rstn,
    input  axi_req_t axi_req,
    output axi_rsp_t axi_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        WDATA,
        WRESP,
        RDATA
    } slv_state_e;

    slv_state_e  state;
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] addr_q;
    logic [7:0]  len_q;
    logic [2:0]  prot_q;
    logic        werr_q;
    logic [31:0] rdata_q;
    logic        rerr_q;
    logic        aw_rdy;
    logic        ar_rdy;
    logic        aw_hs;
    logic        ar_hs;
    logic        w_hs;
    logic        r_hs;
    logic        w_err;
    logic [31:0] rd_addr;
    logic        rd_err;

    function automatic logic beat_err(input logic [31:0] a, input logic [2:0] p);
        beat_err = (a[31:2] >= 30'(MEM_WORDS)) || ((a >= SECURE_BASE) && p[1]);
    endfunction

    assign aw_rdy = (state == IDLE);
    assign ar_rdy = (state == IDLE) && ~axi_req.awvalid;   // writes win a tie.
    assign aw_hs  = aw_rdy & axi_req.awvalid;
    assign ar_hs  = ar_rdy & axi_req.arvalid;
    assign w_hs   = (state == WDATA) & axi_req.wvalid;
    assign r_hs   = (state == RDATA) & axi_req.rready;
    assign w_err  = beat_err(addr_q, prot_q);

    // next word to fetch, first beat or the one after the current.
    assign rd_addr = ar_hs ? axi_req.araddr : addr_q + 32'd4;
    assign rd_err  = beat_err(rd_addr, ar_hs ? axi_req.arprot : prot_q);

    always_ff @(posedge rx_clk or negedge rx_rstn) begin
        if (~rx_rstn) begin
            state  <= IDLE;
            addr_q <= 32'b0;
            len_q  <= 8'b0;
            prot_q <= 3'b0;
            werr_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (aw_hs) begin
                        addr_q <= axi_req.awaddr;
                        len_q  <= axi_req.awlen;
                        prot_q <= axi_req.awprot;
                        werr_q <= 1'b0;
                        state  <= WDATA;
                    end else if (ar_hs) begin
                        addr_q <= axi_req.araddr;
                        len_q  <= axi_req.arlen;
                        prot_q <= axi_req.arprot;
                        state  <= RDATA;
                    end
                end
                WDATA: begin
                    if (w_hs) begin
                        werr_q <= werr_q | w_err;
                        addr_q <= addr_q + 32'd4;
                        if (axi_req.wlast) begin
                            state <= WRESP;
                        end
                    end
                end
                WRESP: begin
                    if (axi_req.bready) begin
                        state <= IDLE;
                    end
                end
                RDATA: begin
                    if (r_hs && len_q == 8'd0) begin
                        state <= IDLE;
                    end else if (r_hs) begin
                        addr_q <= addr_q + 32'd4;
                        len_q  <= len_q - 8'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge rx_clk) begin
        if (w_hs && ~w_err) begin
            for (int i = 0; i < 4; i++) begin
                if (axi_req.wstrb[i]) begin
                    mem[addr_q[MEM_AW+1:2]][8*i +: 8] <= axi_req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (ar_hs || (r_hs && len_q != 8'd0)) begin
            rdata_q <= rd_err ? 32'b0 : mem[rd_addr[MEM_AW+1:2]];
            rerr_q  <= rd_err;
        end
    end

    always_comb begin
        axi_rsp         = '0;
        axi_rsp.awready = aw_rdy;
        axi_rsp.wready  = (state == WDATA);
        axi_rsp.bvalid  = (state == WRESP);
        axi_rsp.bresp   = werr_q ? RESP_SLVERR : RESP_OKAY;
        axi_rsp.arready = ar_rdy;
        axi_rsp.rvalid  = (state == RDATA);
        axi_rsp.rdata   = rdata_q;
        axi_rsp.rresp   = rerr_q ? RESP_SLVERR : RESP_OKAY;
        axi_rsp.rlast   = (state == RDATA) && (len_q == 8'd0);
    end

endmodule

//--- src/cdc_axi_bridge_top.sv
`timescale 1ns/1ps

module cdc_axi_bridge_top
    import mem_req_pkg::*;
    import axi_bridge_pkg::*;
(
    input  logic    tx_clk,
    input  logic    tx_rstn,
    input  logic    rx_clk,
    input  logic    rx_rstn,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic     tx_tog;
    logic     rx_tog;
    mem_req_t tx_req;
    mem_rsp_t rx_rsp;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp;

    mem_req_tx tx_i (
        .tx_clk  (tx_clk),
        .tx_rstn (tx_rstn),
        .wb_req  (wb_req),
        .rx_tog  (rx_tog),
        .rx_rsp  (rx_rsp),
        .wb_rsp  (wb_rsp),
        .tx_tog  (tx_tog),
        .tx_req  (tx_req)
    );

    axi_rx rx_i (
        .rx_clk  (rx_clk),
        .rx_rstn (rx_rstn),
        .tx_tog  (tx_tog),
        .tx_req  (tx_req),
        .axi_rsp (axi_rsp),
        .rx_tog  (rx_tog),
        .rx_rsp  (rx_rsp),
        .axi_req (axi_req)
    );

    axi_sram_slave mem_i (
        .rx_clk  (rx_clk),
        .rx_rstn (rx_rstn),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

endmodule

//--- tests/tb_cdc_axi_bridge.sv
`timescale 1ns/1ps

module tb_cdc_axi_bridge
    import mem_req_pkg::*;
    import axi_bridge_pkg::*;
();

    localparam int          N_TRANS    = 300;
    localparam int          N_PRELOAD  = MEM_WORDS;
    localparam int          MAX_CYCLES = (N_PRELOAD + N_TRANS) * 60;
    localparam logic [31:0] MEM_BYTES  = 32'(MEM_WORDS * 4);

    logic       rx_clk;
    logic       tx_clk;
    logic       rx_rstn;
    logic       tx_rstn;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;

    logic [7:0] model_mem [MEM_WORDS*4];    // byte image of the sram.
    integer     seed;
    int         mismatches;
    int         failures;
    int         rsp_seen;
    int         cycles;

    cdc_axi_bridge_top dut_i (
        .tx_clk  (tx_clk),
        .tx_rstn (tx_rstn),
        .rx_clk  (rx_clk),
        .rx_rstn (rx_rstn),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    always #4 rx_clk = ~rx_clk;
    always #5.5 tx_clk = ~tx_clk;               // unrelated to rx_clk.

    function automatic logic [7:0] fill_byte(input int a);
        fill_byte = 8'(a * 29) ^ 8'(a >> 3);
    endfunction

    // expected result, byte by byte; a bad byte is out of range or secure.
    task automatic model_access(input mem_req_t r, output logic err, output logic [31:0] dat);
        int          i;
        int          n;
        logic [31:0] a;
        logic        bad;
        err = 1'b0;
        dat = 32'b0;
        n   = 1 << r.size;
        for (i = 0; i < n; i++) begin
            a   = r.addr + 32'(i);
            bad = (a >= MEM_BYTES) || ((a >= SECURE_BASE) && r.prot[1] && r.secen);
            err = err | bad;
            if (!bad && r.write) begin
                model_mem[a[MEM_AW+1:0]] = r.wdata[8*i +: 8];
            end else if (!bad) begin
                dat[8*i +: 8] = model_mem[a[MEM_AW+1:0]];
            end
        end
    endtask

    task automatic run_access(input mem_req_t r, output logic err, output logic [31:0] dat);
        @(posedge tx_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, req: r};
        @(negedge tx_clk);
        while (!(wb_rsp.ack || wb_rsp.err)) begin
            @(negedge tx_clk);
        end
        err = wb_rsp.err;
        dat = wb_rsp.dat;
        @(posedge tx_clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        @(negedge tx_clk);
        if (wb_rsp.ack || wb_rsp.err) begin
            $display("protocol error at %0t: response held longer than one cycle", $time);
            failures++;
        end
    endtask

    task automatic check_access(input mem_req_t r);
        logic        exp_err;
        logic [31:0] exp_dat;
        logic        got_err;
        logic [31:0] got_dat;
        model_access(r, exp_err, exp_dat);
        run_access(r, got_err, got_dat);
        if (got_err !== exp_err) begin
            $display("MISMATCH at %0t: %s addr %h size %0d ended with err %b, expected %b",
                     $time, r.write ? "write" : "read", r.addr, r.size, got_err, exp_err);
            mismatches++;
        end
        if (got_dat !== exp_dat) begin
            $display("MISMATCH at %0t: %s addr %h size %0d returned %h, expected %h",
                     $time, r.write ? "write" : "read", r.addr, r.size, got_dat, exp_dat);
            mismatches++;
        end
    endtask

    always @(negedge tx_clk) begin
        if (wb_rsp.ack && wb_rsp.err) begin
            $display("protocol error at %0t: ack and err asserted together", $time);
            failures++;
        end
        if (wb_rsp.ack || wb_rsp.err) begin
            rsp_seen++;
        end
    end

    always @(posedge rx_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d rx_clk cycles", MAX_CYCLES);
            $display("summary: %0d mismatches, %0d other errors", mismatches, failures + 1);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        mem_req_t    r;
        mem_req_t    last;
        logic        last_write;
        logic [31:0] rnd;
        logic [31:0] span;
        int          w;
        int          n;
        rx_clk     = 1'b0;
        tx_clk     = 1'b0;
        rx_rstn    = 1'b0;
        tx_rstn    = 1'b0;
        wb_req     = '0;
        seed       = 32'habb565dc;
        mismatches = 0;
        failures   = 0;
        rsp_seen   = 0;
        cycles     = 0;
        last       = '0;
        last_write = 1'b0;
        fork
            begin
                repeat (2) @(posedge rx_clk);
                rx_rstn <= 1'b1;
            end
            begin
                repeat (2) @(posedge tx_clk);
                tx_rstn <= 1'b1;
            end
        join
        repeat (20) @(posedge rx_clk);           // past the rx ignore window.

        // fill the whole sram with an address pattern.
        for (w = 0; w < N_PRELOAD; w++) begin
            r       = '0;
            r.addr  = 32'(4 * w);
            r.write = 1'b1;
            r.size  = SIZE_WORD;
            r.wdata = {fill_byte(4*w + 3), fill_byte(4*w + 2),
                       fill_byte(4*w + 1), fill_byte(4*w)};
            check_access(r);
        end

        for (n = 0; n < N_TRANS; n++) begin
            rnd  = $random(seed);
            span = 32'(rnd[31:16]);
            if (rnd[3:0] < 4'd10) begin
                r.addr = span % SECURE_BASE;
            end else if (rnd[3:0] < 4'd13) begin
                r.addr = SECURE_BASE + span % (MEM_BYTES - SECURE_BASE);
            end else begin
                r.addr = MEM_BYTES - 32'd8 + span % 32'd16;    // straddles the end.
            end
            case (rnd[5:4])
                2'd0:    r.size = SIZE_BYTE;
                2'd1:    r.size = SIZE_HALF;
                default: r.size = SIZE_WORD;
            endcase
            r.write = rnd[6];
            r.prot  = rnd[13:7];
            r.secen = rnd[14];
            r.wdata = $random(seed);
            if (last_write && rnd[15]) begin
                r.addr  = last.addr;               // read back the last write.
                r.size  = last.size;
                r.write = 1'b0;
            end
            last       = r;
            last_write = r.write;
            check_access(r);
        end

        repeat (4) @(negedge tx_clk);
        if (rsp_seen != N_PRELOAD + N_TRANS) begin
            $display("response count %0d does not match %0d requests",
                     rsp_seen, N_PRELOAD + N_TRANS);
            failures++;
        end
        $display("summary: %0d transactions, %0d mismatches, %0d other errors",
                 N_PRELOAD + N_TRANS, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
src/mem_req_pkg.sv
src/axi_bridge_pkg.sv
src/mem_req_tx.sv
src/axi_rx.sv
src/axi_sram_slave.sv
src/cdc_axi_bridge_top.sv
tests/tb_cdc_axi_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cdc_axi_bridge
RTL_TOP   ?= cdc_axi_bridge_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LINT_FLAGS ?= --timing
SIM_FLAGS  ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
